//--- hw/smpc_params.svh
`ifndef SMPC_PARAMS_SVH
`define SMPC_PARAMS_SVH

`define SMPC_DW             8
`define SMPC_AW             6
`define SMPC_OREG_AW        5
`define SMPC_OREG_BASE      6'h10       // Word address of OREG0

`define SMPC_ADDR_IREG0     7'h01
`define SMPC_ADDR_IREG2     7'h05
`define SMPC_ADDR_COMREG    7'h1F
`define SMPC_ADDR_OREG_END  7'h5F
`define SMPC_ADDR_SR        7'h61
`define SMPC_ADDR_SF        7'h63

`define SMPC_WAIT_W         16
`define SMPC_WAIT_POWER     120         // CE cycles
`define SMPC_WAIT_CD        159
`define SMPC_WAIT_CKCHG     100
`define SMPC_WAIT_NMI       127
`define SMPC_WAIT_STATUS    500

`define SMPC_OREG_CMD_SLOT  5'd31
`define SMPC_AREA_CODE_BYTE 8'h20       // Status byte 1
`define SMPC_AREA_CODE_B2   8'h22
`define SMPC_AREA_CODE_B3   8'h01
`define SMPC_INTBACK_KEY    8'hF0

`endif

//--- hw/smpc_pkg.sv
package smpc_pkg;

	typedef enum logic [7:0] {
		MSHON    = 8'h00,
		SSHON    = 8'h02,
		SSHOFF   = 8'h03,
		SNDON    = 8'h06,
		SNDOFF   = 8'h07,
		CDON     = 8'h08,
		CDOFF    = 8'h09,
		SYSRES   = 8'h0D,
		CKCHG352 = 8'h0E,
		CKCHG320 = 8'h0F,
		INTBACK  = 8'h10,
		NMIREQ   = 8'h18,
		RESENAB  = 8'h19,
		RESDISA  = 8'h1A
	} smpc_cmd_e;

	typedef enum logic [4:0] {
		IDLE  = 5'b00001,
		START = 5'b00010,
		WAIT  = 5'b00100,
		EXEC  = 5'b01000,
		END   = 5'b10000
	} smpc_seq_state_e;

endpackage

//--- hw/smpc_cmd_if.sv
`include "smpc_params.svh"

interface smpc_cmd_if;
	smpc_pkg::smpc_cmd_e  comreg;
	logic                 start;        // COMREG written
	logic [`SMPC_DW-1:0]  ireg0;
	logic [`SMPC_DW-1:0]  ireg2;
	logic                 done;         // Clears SF
	logic [2:0]           sr_hi;

	modport host (
		output comreg, start, ireg0, ireg2,
		input  done, sr_hi
	);

	modport seq (
		input  comreg, start, ireg0, ireg2,
		output done, sr_hi
	);
endinterface

//--- hw/smpc_oreg_ram.sv
`include "smpc_params.svh"

module smpc_oreg_ram (
	input  logic                     CLK,
	input  logic                     we,
	input  logic [`SMPC_OREG_AW-1:0] wa,
	input  logic [`SMPC_DW-1:0]      d,
	input  logic [`SMPC_OREG_AW-1:0] ra,
	output logic [`SMPC_DW-1:0]      q
);
	logic [`SMPC_DW-1:0] mem [0:(1 << `SMPC_OREG_AW)-1];

	initial begin
		mem = '{default: '0};    // Power-up contents
	end

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[wa] <= d;
		end
	end

	assign q = mem[ra];    // Async read port
endmodule

//--- hw/smpc_host_regs.sv
`include "smpc_params.svh"

module smpc_host_regs (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  logic [`SMPC_AW-1:0]      a,
	input  logic [`SMPC_DW-1:0]      di,
	input  logic                     cs_n,
	input  logic                     rw_n,
	output logic [`SMPC_DW-1:0]      do_q,
	output logic [`SMPC_OREG_AW-1:0] ram_ra,
	input  logic [`SMPC_DW-1:0]      ram_q,
	smpc_cmd_if.host                 cmd
);
	logic       rw_n_old;
	logic       cs_n_old;
	logic       wr_stb;
	logic       rd_stb;
	logic       sf;
	logic [6:0] byte_addr;

	assign byte_addr = {a, 1'b1};    // Odd byte lane only
	assign wr_stb    = !rw_n && rw_n_old && !cs_n;
	assign rd_stb    = !cs_n && cs_n_old && rw_n;
	assign ram_ra    = `SMPC_OREG_AW'(a - `SMPC_OREG_BASE);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old   <= 1'b1;
			cs_n_old   <= 1'b1;
			cmd.ireg0  <= '0;
			cmd.ireg2  <= '0;
			cmd.comreg <= smpc_pkg::MSHON;
			cmd.start  <= 1'b0;
			sf         <= 1'b0;
		end else begin
			rw_n_old  <= rw_n;
			cs_n_old  <= cs_n;
			cmd.start <= 1'b0;

			if (cmd.done) begin
				sf <= 1'b0;
			end

			if (wr_stb) begin
				case (byte_addr)
					`SMPC_ADDR_IREG0: begin
						cmd.ireg0 <= di;
					end
					`SMPC_ADDR_IREG2: begin
						cmd.ireg2 <= di;
					end
					`SMPC_ADDR_COMREG: begin
						cmd.comreg <= smpc_pkg::smpc_cmd_e'(di);
						cmd.start  <= 1'b1;
					end
					`SMPC_ADDR_SF: begin
						if (di[0]) begin
							sf <= 1'b1;    // Host may only set
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Read data mux
	always_ff @(posedge CLK) begin
		if (rd_stb) begin
			if (byte_addr <= `SMPC_ADDR_OREG_END) begin
				do_q <= ram_q;
			end else if (byte_addr == `SMPC_ADDR_SR) begin
				do_q <= {cmd.sr_hi, 5'b00000};
			end else if (byte_addr == `SMPC_ADDR_SF) begin
				do_q <= {7'b0000000, sf};
			end else begin
				do_q <= '0;
			end
		end
	end
endmodule

//--- hw/smpc_cmd_seq.sv
`include "smpc_params.svh"

module smpc_cmd_seq (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  logic                     ce,
	input  logic                     mres_n,
	input  logic [3:0]               ac,
	smpc_cmd_if.seq                  cmd,
	output logic                     oreg_we,
	output logic [`SMPC_OREG_AW-1:0] oreg_wa,
	output logic [`SMPC_DW-1:0]      oreg_d,
	output logic                     mshres_n,
	output logic                     mshnmi_n,
	output logic                     sshres_n,
	output logic                     sshnmi_n,
	output logic                     sysres_n,
	output logic                     sndres_n,
	output logic                     cdres_n,
	output logic                     mirq_n,
	output logic                     dotsel
);
	smpc_pkg::smpc_seq_state_e state;
	smpc_pkg::smpc_cmd_e       cmd_q;      // Command being run
	logic [`SMPC_WAIT_W-1:0]   wait_cnt;
	logic [`SMPC_OREG_AW-1:0]  oreg_cnt;
	logic [`SMPC_DW-1:0]       stat_byte;
	logic                      pending;
	logic                      take;
	logic                      stat_req;
	logic                      resd;

	assign take = ce && mres_n && state == smpc_pkg::IDLE && (pending || cmd.start);

	// COMREG writes queue here while a command runs
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pending <= 1'b0;
		end else if (take) begin
			pending <= 1'b0;
		end else if (cmd.start) begin
			pending <= 1'b1;
		end
	end

	always_comb begin
		case (oreg_cnt)
			5'd0:                stat_byte = {1'b0, resd, 6'b000000};
			5'd1:                stat_byte = `SMPC_AREA_CODE_BYTE;
			5'd2:                stat_byte = `SMPC_AREA_CODE_B2;
			5'd3:                stat_byte = `SMPC_AREA_CODE_B3;
			5'd9:                stat_byte = {4'b0000, ac};
			5'd10:               stat_byte = {1'b0, dotsel, 2'b11, ~mshnmi_n, 1'b1,
			                                  ~sysres_n, ~sndres_n};
			5'd11:               stat_byte = {1'b0, ~cdres_n, 6'b000000};
			`SMPC_OREG_CMD_SLOT: stat_byte = cmd_q;
			default:             stat_byte = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= smpc_pkg::IDLE;
			cmd_q     <= smpc_pkg::MSHON;
			wait_cnt  <= '0;
			oreg_cnt  <= '0;
			stat_req  <= 1'b0;
			cmd.done  <= 1'b0;
			cmd.sr_hi <= 3'b000;
			oreg_we   <= 1'b0;
			oreg_wa   <= '0;
			oreg_d    <= '0;
			{mshres_n, mshnmi_n, sshres_n, sshnmi_n} <= 4'b0000;
			{sysres_n, sndres_n, cdres_n}            <= 3'b000;
			mirq_n    <= 1'b1;
			dotsel    <= 1'b0;
			resd      <= 1'b1;
		end else begin
			oreg_we  <= 1'b0;
			cmd.done <= 1'b0;
			if (!mres_n) begin    // Power-on levels, FSM frozen
				{mshres_n, mshnmi_n, sshres_n, sshnmi_n} <= 4'b1101;
				{sysres_n, sndres_n, cdres_n}            <= 3'b101;
				mirq_n    <= 1'b1;
				dotsel    <= 1'b0;
				cmd.sr_hi <= 3'b000;
				resd      <= 1'b1;
			end else if (ce) begin
				case (state)
					smpc_pkg::IDLE: begin
						mirq_n <= 1'b1;
						if (take) begin
							cmd_q <= cmd.comreg;
							state <= smpc_pkg::START;
						end
					end
					smpc_pkg::START: begin
						oreg_cnt <= '0;
						stat_req <= 1'b0;
						state    <= smpc_pkg::WAIT;
						case (cmd_q)
							smpc_pkg::MSHON, smpc_pkg::SSHON, smpc_pkg::SSHOFF,
							smpc_pkg::SNDON, smpc_pkg::SNDOFF:
								wait_cnt <= `SMPC_WAIT_W'(`SMPC_WAIT_POWER);
							smpc_pkg::CDON, smpc_pkg::CDOFF:
								wait_cnt <= `SMPC_WAIT_W'(`SMPC_WAIT_CD);
							smpc_pkg::SYSRES:
								wait_cnt <= '0;
							smpc_pkg::CKCHG352, smpc_pkg::CKCHG320:
								wait_cnt <= `SMPC_WAIT_W'(`SMPC_WAIT_CKCHG);
							smpc_pkg::NMIREQ, smpc_pkg::RESENAB, smpc_pkg::RESDISA:
								wait_cnt <= `SMPC_WAIT_W'(`SMPC_WAIT_NMI);
							smpc_pkg::INTBACK: begin
								if (cmd.ireg2 == `SMPC_INTBACK_KEY && cmd.ireg0[0]) begin
									stat_req <= 1'b1;
									wait_cnt <= `SMPC_WAIT_W'(`SMPC_WAIT_STATUS);
								end else begin
									wait_cnt <= '0;    // Echo only
								end
							end
							default: state <= smpc_pkg::EXEC;
						endcase
					end
					smpc_pkg::WAIT: begin
						if (wait_cnt == '0) begin
							state <= smpc_pkg::EXEC;
						end else begin
							wait_cnt <= wait_cnt - 1'b1;
						end
					end
					smpc_pkg::EXEC: begin
						oreg_we <= 1'b1;
						oreg_wa <= `SMPC_OREG_CMD_SLOT;
						oreg_d  <= cmd_q;
						state   <= smpc_pkg::END;
						case (cmd_q)
							smpc_pkg::MSHON:  {mshres_n, mshnmi_n} <= 2'b11;
							smpc_pkg::SSHON:  {sshres_n, sshnmi_n} <= 2'b11;
							smpc_pkg::SSHOFF: {sshres_n, sshnmi_n} <= 2'b01;
							smpc_pkg::SNDON:  sndres_n <= 1'b1;
							smpc_pkg::SNDOFF: sndres_n <= 1'b0;
							smpc_pkg::CDON:   cdres_n <= 1'b1;
							smpc_pkg::CDOFF:  cdres_n <= 1'b0;
							smpc_pkg::SYSRES: begin
								{mshres_n, mshnmi_n, sshres_n, sshnmi_n} <= 4'b0000;
								{sysres_n, sndres_n, cdres_n}            <= 3'b000;
							end
							smpc_pkg::CKCHG352, smpc_pkg::CKCHG320: begin
								{mshnmi_n, sshres_n, sshnmi_n} <= 3'b000;
								{sysres_n, sndres_n}           <= 2'b00;
								dotsel <= (cmd_q == smpc_pkg::CKCHG352);
							end
							smpc_pkg::NMIREQ:  mshnmi_n <= 1'b0;
							smpc_pkg::RESENAB: resd <= 1'b0;
							smpc_pkg::RESDISA: resd <= 1'b1;
							smpc_pkg::INTBACK: begin
								if (stat_req) begin    // One OREG per cycle
									oreg_wa  <= oreg_cnt;
									oreg_d   <= stat_byte;
									oreg_cnt <= oreg_cnt + 1'b1;
									if (oreg_cnt != `SMPC_OREG_CMD_SLOT) begin
										state <= smpc_pkg::EXEC;
									end else begin
										cmd.sr_hi <= 3'b010;
										mirq_n    <= 1'b0;
									end
								end
							end
							default: begin
							end
						endcase
					end
					smpc_pkg::END: begin
						case (cmd_q)
							smpc_pkg::SYSRES: begin
								{mshres_n, mshnmi_n, sshres_n, sshnmi_n} <= 4'b1111;
								{sysres_n, sndres_n, cdres_n}            <= 3'b111;
							end
							smpc_pkg::CKCHG352, smpc_pkg::CKCHG320:
								{mshnmi_n, sndres_n, sysres_n} <= 3'b111;
							smpc_pkg::NMIREQ: mshnmi_n <= 1'b1;
							default: begin
							end
						endcase
						cmd.done <= 1'b1;
						state    <= smpc_pkg::IDLE;
					end
					default: state <= smpc_pkg::IDLE;
				endcase
			end
		end
	end
endmodule

//--- hw/smpc_top.sv
`include "smpc_params.svh"

module smpc_top (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               CE,
	input  logic               MRES_N,
	input  logic [3:0]         AC,
	input  logic [6:1]         A,
	input  logic [`SMPC_DW-1:0] DI,
	output logic [`SMPC_DW-1:0] DO,
	input  logic               CS_N,
	input  logic               RW_N,
	output logic               MSHRES_N,
	output logic               MSHNMI_N,
	output logic               SSHRES_N,
	output logic               SSHNMI_N,
	output logic               SYSRES_N,
	output logic               SNDRES_N,
	output logic               CDRES_N,
	output logic               MIRQ_N,
	output logic               DOTSEL
);
	logic                     oreg_we;
	logic [`SMPC_OREG_AW-1:0] oreg_wa;
	logic [`SMPC_DW-1:0]      oreg_d;
	logic [`SMPC_OREG_AW-1:0] ram_ra;
	logic [`SMPC_DW-1:0]      ram_q;

	smpc_cmd_if cmd_if ();

	smpc_host_regs u_host_regs (
		.CLK, .RST_N, .a(A), .di(DI), .cs_n(CS_N), .rw_n(RW_N), .do_q(DO),
		.ram_ra, .ram_q, .cmd(cmd_if.host)
	);

	smpc_cmd_seq u_cmd_seq (
		.CLK, .RST_N, .ce(CE), .mres_n(MRES_N), .ac(AC), .cmd(cmd_if.seq),
		.oreg_we, .oreg_wa, .oreg_d,
		.mshres_n(MSHRES_N), .mshnmi_n(MSHNMI_N), .sshres_n(SSHRES_N),
		.sshnmi_n(SSHNMI_N), .sysres_n(SYSRES_N), .sndres_n(SNDRES_N),
		.cdres_n(CDRES_N), .mirq_n(MIRQ_N), .dotsel(DOTSEL)
	);

	smpc_oreg_ram u_oreg_ram (
		.CLK, .we(oreg_we), .wa(oreg_wa), .d(oreg_d), .ra(ram_ra), .q(ram_q)
	);
endmodule

//--- tests/smpc_tb.sv
`include "smpc_params.svh"

module smpc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int         TIMEOUT_CYCLES = 20000;    // ~30 commands of up to ~600 cycles
	localparam logic [3:0] AC_VALUE = 4'h5;

	logic       CLK;
	logic       RST_N;
	logic       ce;
	logic       mres_n;
	logic [3:0] ac;
	logic [6:1] a;
	logic [7:0] di;
	logic [7:0] dout;
	logic       cs_n;
	logic       rw_n;
	logic       mshres_n;
	logic       mshnmi_n;
	logic       sshres_n;
	logic       sshnmi_n;
	logic       sysres_n;
	logic       sndres_n;
	logic       cdres_n;
	logic       mirq_n;
	logic       dotsel;

	// Expected line levels
	logic exp_mshres_n;
	logic exp_mshnmi_n;
	logic exp_sshres_n;
	logic exp_sshnmi_n;
	logic exp_sysres_n;
	logic exp_sndres_n;
	logic exp_cdres_n;
	logic exp_dotsel;
	logic exp_resd;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int mirq_low_cycles = 0;
	int seed = 53787;

	smpc_top uut (
		.CLK, .RST_N, .CE(ce), .MRES_N(mres_n), .AC(ac), .A(a), .DI(di), .DO(dout),
		.CS_N(cs_n), .RW_N(rw_n), .MSHRES_N(mshres_n), .MSHNMI_N(mshnmi_n),
		.SSHRES_N(sshres_n), .SSHNMI_N(sshnmi_n), .SYSRES_N(sysres_n),
		.SNDRES_N(sndres_n), .CDRES_N(cdres_n), .MIRQ_N(mirq_n), .DOTSEL(dotsel)
	);

	always #20 CLK = ~CLK;

	always @(negedge CLK) begin
		if (mirq_n === 1'b0) begin
			mirq_low_cycles++;
		end
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a command never cleared SF", cycle_count);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [6:0] oreg_addr(input int idx);
		logic [5:0] word;
		word = `SMPC_OREG_BASE + 6'(idx);
		return {word, 1'b1};
	endfunction

	function automatic logic is_known_code(input logic [7:0] code);
		case (code)
			8'h00, 8'h02, 8'h03, 8'h06, 8'h07, 8'h08, 8'h09, 8'h0D,
			8'h0E, 8'h0F, 8'h10, 8'h18, 8'h19, 8'h1A: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Status block byte from the current line model
	function automatic logic [7:0] expected_status(input int idx);
		case (idx)
			0: return {1'b0, exp_resd, 6'b000000};
			1: return `SMPC_AREA_CODE_BYTE;
			2: return `SMPC_AREA_CODE_B2;
			3: return `SMPC_AREA_CODE_B3;
			9: return {4'b0000, AC_VALUE};
			10: return {1'b0, exp_dotsel, 2'b11, ~exp_mshnmi_n, 1'b1, ~exp_sysres_n,
			            ~exp_sndres_n};
			11: return {1'b0, ~exp_cdres_n, 6'b000000};
			default: return 8'h00;
		endcase
	endfunction

	task automatic compare_byte(input string name, input logic [7:0] expected,
	                            input logic [7:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0d ns: %s expected 0x%02h, got 0x%02h", $time, name,
			         expected, actual);
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_lines();
		compare_bit("MSHRES_N", exp_mshres_n, mshres_n);
		compare_bit("MSHNMI_N", exp_mshnmi_n, mshnmi_n);
		compare_bit("SSHRES_N", exp_sshres_n, sshres_n);
		compare_bit("SSHNMI_N", exp_sshnmi_n, sshnmi_n);
		compare_bit("SYSRES_N", exp_sysres_n, sysres_n);
		compare_bit("SNDRES_N", exp_sndres_n, sndres_n);
		compare_bit("CDRES_N", exp_cdres_n, cdres_n);
		compare_bit("MIRQ_N", 1'b1, mirq_n);
		compare_bit("DOTSEL", exp_dotsel, dotsel);
	endtask

	// Called right after a falling edge
	task automatic write_reg(input logic [6:0] byte_addr, input logic [7:0] data);
		a = byte_addr[6:1];
		di = data;
		cs_n = 1'b0;
		rw_n = 1'b0;
		@(negedge CLK);
		cs_n = 1'b1;
		rw_n = 1'b1;
		@(negedge CLK);    // Idle cycle
	endtask

	task automatic read_reg(input logic [6:0] byte_addr, output logic [7:0] data);
		a = byte_addr[6:1];
		cs_n = 1'b0;
		rw_n = 1'b1;
		@(negedge CLK);
		data = dout;    // Latched on the last rising edge
		cs_n = 1'b1;
		@(negedge CLK);
	endtask

	task automatic apply_to_model(input logic [7:0] code);
		case (code)
			smpc_pkg::MSHON: begin
				exp_mshres_n = 1'b1;
				exp_mshnmi_n = 1'b1;
			end
			smpc_pkg::SSHON: begin
				exp_sshres_n = 1'b1;
				exp_sshnmi_n = 1'b1;
			end
			smpc_pkg::SSHOFF: exp_sshres_n = 1'b0;
			smpc_pkg::SNDON: exp_sndres_n = 1'b1;
			smpc_pkg::SNDOFF: exp_sndres_n = 1'b0;
			smpc_pkg::CDON: exp_cdres_n = 1'b1;
			smpc_pkg::CDOFF: exp_cdres_n = 1'b0;
			smpc_pkg::SYSRES: begin
				{exp_mshres_n, exp_mshnmi_n, exp_sshres_n, exp_sshnmi_n} = 4'b1111;
				{exp_sysres_n, exp_sndres_n, exp_cdres_n} = 3'b111;
			end
			smpc_pkg::CKCHG352, smpc_pkg::CKCHG320: begin
				{exp_mshnmi_n, exp_sysres_n, exp_sndres_n} = 3'b111;    // After the pulse
				{exp_sshres_n, exp_sshnmi_n} = 2'b00;
				exp_dotsel = (code == smpc_pkg::CKCHG352);
			end
			smpc_pkg::NMIREQ: exp_mshnmi_n = 1'b1;
			smpc_pkg::RESENAB: exp_resd = 1'b0;
			smpc_pkg::RESDISA: exp_resd = 1'b1;
			default: begin
			end
		endcase
	endtask

	task automatic run_cmd(input logic [7:0] code);
		logic [7:0] sf_val;
		logic [7:0] echo;
		write_reg(`SMPC_ADDR_SF, 8'h01);
		write_reg(`SMPC_ADDR_COMREG, code);
		sf_val = 8'h01;
		while (sf_val[0]) begin
			read_reg(`SMPC_ADDR_SF, sf_val);
		end
		apply_to_model(code);
		check_lines();
		read_reg(oreg_addr(`SMPC_OREG_CMD_SLOT), echo);
		compare_byte("OREG31", code, echo);
	endtask

	task automatic pulse_master_reset();
		logic [7:0] val;
		mres_n = 1'b0;
		repeat (3) @(negedge CLK);
		{exp_mshres_n, exp_mshnmi_n, exp_sshres_n, exp_sshnmi_n} = 4'b1101;
		{exp_sysres_n, exp_sndres_n, exp_cdres_n, exp_dotsel} = 4'b1010;
		exp_resd = 1'b1;
		check_lines();
		read_reg(`SMPC_ADDR_SR, val);
		compare_byte("SR", 8'h00, val);
		mres_n = 1'b1;
		@(negedge CLK);
		check_lines();    // Levels held after release
	endtask

	task automatic reset_checks();
		logic [7:0] val;
		{exp_mshres_n, exp_mshnmi_n, exp_sshres_n, exp_sshnmi_n} = 4'b0000;
		{exp_sysres_n, exp_sndres_n, exp_cdres_n, exp_dotsel} = 4'b0000;
		exp_resd = 1'b1;
		check_lines();
		read_reg(`SMPC_ADDR_SF, val);
		compare_byte("SF", 8'h00, val);
		read_reg(`SMPC_ADDR_SR, val);
		compare_byte("SR", 8'h00, val);
		read_reg(oreg_addr(`SMPC_OREG_CMD_SLOT), val);
		compare_byte("OREG31", 8'h00, val);
		pulse_master_reset();
	endtask

	task automatic power_cmds();
		run_cmd(smpc_pkg::MSHON);
		run_cmd(smpc_pkg::SSHON);
		run_cmd(smpc_pkg::SSHOFF);
		run_cmd(smpc_pkg::SNDON);
		run_cmd(smpc_pkg::SNDOFF);
		run_cmd(smpc_pkg::CDON);
		run_cmd(smpc_pkg::CDOFF);
	endtask

	task automatic system_cmds();
		run_cmd(smpc_pkg::SYSRES);
		run_cmd(smpc_pkg::CKCHG352);
		run_cmd(smpc_pkg::CKCHG320);
		run_cmd(smpc_pkg::NMIREQ);
	endtask

	task automatic echo_unused();
		logic [7:0] code;
		for (int n = 0; n < 5; n++) begin
			code = 8'($random(seed));
			while (is_known_code(code)) begin
				code = 8'($random(seed));
			end
			run_cmd(code);
		end
	endtask

	task automatic intback_status();
		logic [7:0] val;
		logic [7:0] oreg0_before;
		int         low_before;
		run_cmd(smpc_pkg::RESENAB);
		write_reg(`SMPC_ADDR_IREG2, `SMPC_INTBACK_KEY);
		write_reg(`SMPC_ADDR_IREG0, 8'h01);
		low_before = mirq_low_cycles;
		run_cmd(smpc_pkg::INTBACK);
		checks++;
		if (mirq_low_cycles == low_before) begin
			errors++;
			$display("MIRQ_N never went low during INTBACK with a status request");
		end
		for (int i = 0; i < 12; i++) begin
			read_reg(oreg_addr(i), val);
			compare_byte($sformatf("OREG%0d", i), expected_status(i), val);
		end
		read_reg(`SMPC_ADDR_SR, val);
		compare_byte("SR", 8'h40, val);
		pulse_master_reset();    // SR is set here, so master reset must clear it
		read_reg(oreg_addr(0), oreg0_before);
		run_cmd(smpc_pkg::RESDISA);    // A status write would now change OREG0
		write_reg(`SMPC_ADDR_IREG2, 8'h00);
		low_before = mirq_low_cycles;
		run_cmd(smpc_pkg::INTBACK);
		checks++;
		if (mirq_low_cycles != low_before) begin
			errors++;
			$display("MIRQ_N went low on INTBACK without the status key");
		end
		read_reg(oreg_addr(0), val);
		compare_byte("OREG0", oreg0_before, val);
	endtask

	initial begin
		CLK = 1'b0;
		RST_N = 1'b0;
		ce = 1'b1;
		mres_n = 1'b1;
		ac = AC_VALUE;
		a = '0;
		di = '0;
		cs_n = 1'b1;
		rw_n = 1'b1;
		repeat (3) @(negedge CLK);
		RST_N = 1'b1;
		reset_checks();
		power_cmds();
		system_cmds();
		echo_unused();
		intback_status();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end
endmodule

//--- build.f
+incdir+hw
hw/smpc_pkg.sv
hw/smpc_cmd_if.sv
hw/smpc_oreg_ram.sv
hw/smpc_host_regs.sv
hw/smpc_cmd_seq.sv
hw/smpc_top.sv
tests/smpc_tb.sv

//--- Makefile
TOP = smpc_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf obj_dir
